//--- list.f
hostTapPkg.sv
writePacketTracker.sv
tapCsr.sv
fiuTap.sv
hostTapTop.sv
tbHostTap.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tbHostTap
FILELIST  := list.f
OBJDIR    := obj_dir

SOURCES := $(shell cat $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN)

clean:
	rm -rf $(OBJDIR)

//--- tbHostTap.sv
// Self-checking testbench for the host tap. A table of APB, AFU write, MMIO and
// response cycles is built first and then applied one row per cycle to hostTapTop
`timescale 1ns/100ps
`default_nettype none

module tbHostTap;

    // What a table row does on the DUT inputs
    typedef enum logic [2:0] {
        opIdle, opApbWrite, opApbRead, opAfuBeat, opMmioPulse, opResponse
    } tOp;

    // Stimulus for one cycle and the outputs expected in that cycle
    typedef struct {
        tOp                                   op;
        logic [hostTapPkg::lineAddrWidth-1:0] addr;
        logic [hostTapPkg::lineDataWidth-1:0] data;
        hostTapPkg::tReqType                  reqType;
        logic [hostTapPkg::mdataWidth-1:0]    mdata;
        logic                                 sop;
        hostTapPkg::tBeatLen                  len;
        hostTapPkg::tRspType                  rspType;
        logic                                 almFull;
        logic                                 expTxValid;
        hostTapPkg::tReqType                  expTxType;
        logic [hostTapPkg::lineAddrWidth-1:0] expTxAddr;
        logic [hostTapPkg::mdataWidth-1:0]    expTxMdata;
        logic [hostTapPkg::lineDataWidth-1:0] expTxData;
        logic                                 expTxSop;
        hostTapPkg::tBeatLen                  expTxLen;
        logic                                 expRxValid;
        logic [hostTapPkg::apbDataWidth-1:0]  expPrdata;
        logic                                 expPslverr;
    } tRow;

    logic                                  clk;
    logic                                  reset;
    logic                                  psel;
    logic                                  penable;
    logic                                  pwrite;
    logic [hostTapPkg::apbAddrWidth-1:0]   paddr;
    logic [hostTapPkg::apbDataWidth-1:0]   pwdata;
    logic [hostTapPkg::apbDataWidth-1:0]   prdata;
    logic                                  pready;
    logic                                  pslverr;
    logic                                  afuC1TxValid;
    hostTapPkg::tReqType                   afuC1TxType;
    logic [hostTapPkg::lineAddrWidth-1:0]  afuC1TxAddr;
    logic [hostTapPkg::mdataWidth-1:0]     afuC1TxMdata;
    logic [hostTapPkg::lineDataWidth-1:0]  afuC1TxData;
    logic                                  afuC1TxSop;
    hostTapPkg::tBeatLen                   afuC1TxLen;
    logic                                  afuC1TxAlmFull;
    logic                                  afuC1RxValid;
    hostTapPkg::tRspType                   afuC1RxType;
    logic [hostTapPkg::mdataWidth-1:0]     afuC1RxMdata;
    logic                                  afuMmioRspValid;
    logic [hostTapPkg::mmioDataWidth-1:0]  afuMmioRspData;
    logic                                  fiuC1TxValid;
    hostTapPkg::tReqType                   fiuC1TxType;
    logic [hostTapPkg::lineAddrWidth-1:0]  fiuC1TxAddr;
    logic [hostTapPkg::mdataWidth-1:0]     fiuC1TxMdata;
    logic [hostTapPkg::lineDataWidth-1:0]  fiuC1TxData;
    logic                                  fiuC1TxSop;
    hostTapPkg::tBeatLen                   fiuC1TxLen;
    logic                                  fiuC1TxAlmFull;
    logic                                  fiuC1RxValid;
    hostTapPkg::tRspType                   fiuC1RxType;
    logic [hostTapPkg::mdataWidth-1:0]     fiuC1RxMdata;

    tRow         rows[$];
    logic        tableReady = 1'b0;
    logic [31:0] lfsrState = 32'h7e944af0;

    hostTapTop uut (.*);

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Gathers count random bits, one LFSR step per bit
    task automatic takeRandom(input int count, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[126:0], lfsrState[0]};
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
        abortRun($sformatf("FAILED t=%0t %s expected %0h actual %0h",
                           $time, name, expected, actual));
    endtask

    // An idle row; every other row starts from this one
    function automatic tRow blankRow();
        tRow r;
        r.op         = opIdle;
        r.addr       = '0;
        r.data       = '0;
        r.reqType    = hostTapPkg::eReqWrLineI;
        r.mdata      = '0;
        r.sop        = 1'b0;
        r.len        = hostTapPkg::eLen1;
        r.rspType    = hostTapPkg::eRspWrLine;
        r.almFull    = 1'b0;
        r.expTxValid = 1'b0;
        r.expTxType  = hostTapPkg::eReqWrLineI;
        r.expTxAddr  = '0;
        r.expTxMdata = '0;
        r.expTxData  = '0;
        r.expTxSop   = 1'b0;
        r.expTxLen   = hostTapPkg::eLen1;
        r.expRxValid = 1'b0;
        r.expPrdata  = '0;
        r.expPslverr = 1'b0;
        return r;
    endfunction

    // For reads, value is the expected prdata; for writes it is pwdata
    task automatic apbAccess(input logic isWrite, input logic [7:0] addr,
                             input logic [31:0] value, input logic expErr);
        tRow r;
        r = blankRow();
        r.op         = isWrite ? opApbWrite : opApbRead;
        r.addr       = {24'd0, addr};
        r.data       = {96'd0, value};
        r.expPrdata  = value;
        r.expPslverr = expErr;
        rows.push_back(r);
    endtask

    // AFU beat with random data that must appear unchanged on the platform side
    task automatic afuBeat(input hostTapPkg::tReqType reqType, input logic [31:0] addr,
                           input logic [15:0] mdata, input logic sop,
                           input hostTapPkg::tBeatLen len);
        tRow r;
        r = blankRow();
        r.op      = opAfuBeat;
        r.reqType = reqType;
        r.addr    = addr;
        r.mdata   = mdata;
        r.sop     = sop;
        r.len     = len;
        takeRandom(128, r.data);
        r.expTxValid = 1'b1;
        r.expTxType  = reqType;
        r.expTxAddr  = addr;
        r.expTxMdata = mdata;
        r.expTxData  = r.data;
        r.expTxSop   = sop;
        r.expTxLen   = len;
        rows.push_back(r);
    endtask

    task automatic idleCycle(input logic almFull);
        tRow r;
        r = blankRow();
        r.almFull = almFull;
        rows.push_back(r);
    endtask

    // Idle with a random almFull for cycles where nothing can be injected
    task automatic quietCycle();
        logic [127:0] bits;
        takeRandom(1, bits);
        idleCycle(bits[0]);
    endtask

    // Idle cycle in which the tap must place a tagged single-beat WrLineI
    task automatic expectInjected(input logic [31:0] lineAddr, input logic [127:0] lineData);
        tRow r;
        r = blankRow();
        r.expTxValid = 1'b1;
        r.expTxType  = hostTapPkg::eReqWrLineI;
        r.expTxAddr  = lineAddr;
        r.expTxMdata = hostTapPkg::tapWriteTag;
        r.expTxData  = lineData;
        r.expTxSop   = 1'b1;
        r.expTxLen   = hostTapPkg::eLen1;
        rows.push_back(r);
    endtask

    task automatic mmioPulse(input logic [63:0] value);
        tRow r;
        r = blankRow();
        r.op   = opMmioPulse;
        r.data = {64'd0, value};
        rows.push_back(r);
    endtask

    task automatic response(input hostTapPkg::tRspType rspType, input logic [15:0] mdata,
                            input logic expValid);
        tRow r;
        r = blankRow();
        r.op         = opResponse;
        r.rspType    = rspType;
        r.mdata      = mdata;
        r.expRxValid = expValid;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [127:0] mmioA;
        logic [127:0] mmioB;
        // Registers, including an unmapped write that must change nothing
        apbAccess(1'b0, 8'h00, 32'h0000_0000, 1'b0);
        apbAccess(1'b1, 8'h00, 32'h1000_0040, 1'b0);
        apbAccess(1'b0, 8'h00, 32'h1000_0040, 1'b0);
        apbAccess(1'b0, 8'h04, 32'h0000_0000, 1'b0);
        apbAccess(1'b0, 8'h08, 32'h0000_0000, 1'b1);
        apbAccess(1'b0, 8'h10, 32'h0000_0000, 1'b1);
        apbAccess(1'b1, 8'h0C, 32'hFFFF_FFFF, 1'b1);
        apbAccess(1'b0, 8'h00, 32'h1000_0040, 1'b0);
        // Pass-through of every opcode while the DSM base is still invalid
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_1000, 16'h0001, 1'b1, hostTapPkg::eLen1);
        quietCycle();
        afuBeat(hostTapPkg::eReqWrLineM, 32'h0000_2000, 16'h0002, 1'b1, hostTapPkg::eLen2);
        afuBeat(hostTapPkg::eReqWrLineM, 32'h0000_2001, 16'h0003, 1'b0, hostTapPkg::eLen2);
        quietCycle();
        afuBeat(hostTapPkg::eReqWrFence, 32'h0000_0000, 16'h0004, 1'b1, hostTapPkg::eLen1);
        quietCycle();
        // Base becomes valid with a 4-beat packet open; the AFU-ID must wait for
        // the packet, a further AFU beat and two almost-full cycles
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_3000, 16'h0010, 1'b1, hostTapPkg::eLen4);
        apbAccess(1'b1, 8'h04, 32'h0000_0001, 1'b0);
        idleCycle(1'b0);
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_3001, 16'h0011, 1'b0, hostTapPkg::eLen4);
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_3002, 16'h0012, 1'b0, hostTapPkg::eLen4);
        idleCycle(1'b0);
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_3003, 16'h0013, 1'b0, hostTapPkg::eLen4);
        afuBeat(hostTapPkg::eReqWrLineM, 32'h0000_4000, 16'h0020, 1'b1, hostTapPkg::eLen1);
        idleCycle(1'b1);
        idleCycle(1'b1);
        expectInjected(32'h1000_0040, hostTapPkg::afuId);
        idleCycle(1'b0);
        apbAccess(1'b0, 8'h04, 32'h0000_0001, 1'b0);
        // MMIO response goes to DSM line 1 in the first free cycle
        takeRandom(64, mmioA);
        mmioPulse(mmioA[63:0]);
        afuBeat(hostTapPkg::eReqWrLineI, 32'h0000_5000, 16'h0030, 1'b1, hostTapPkg::eLen1);
        idleCycle(1'b1);
        expectInjected(32'h1000_0041, {63'd0, 1'b1, mmioA[63:0]});
        idleCycle(1'b0);
        // Re-arm with a new base and a response already buffered
        apbAccess(1'b1, 8'h04, 32'h0000_0000, 1'b0);
        takeRandom(64, mmioB);
        mmioPulse(mmioB[63:0]);
        quietCycle();
        apbAccess(1'b1, 8'h00, 32'h2000_0100, 1'b0);
        apbAccess(1'b1, 8'h04, 32'h0000_0001, 1'b0);
        expectInjected(32'h2000_0100, hostTapPkg::afuId);
        expectInjected(32'h2000_0101, {63'd0, 1'b1, mmioB[63:0]});
        idleCycle(1'b0);
        apbAccess(1'b0, 8'h00, 32'h2000_0100, 1'b0);
        // Only WrLine completions with the tap tag are hidden from the AFU
        response(hostTapPkg::eRspWrLine, hostTapPkg::tapWriteTag, 1'b0);
        response(hostTapPkg::eRspWrLine, 16'h1234, 1'b1);
        response(hostTapPkg::eRspWrFence, hostTapPkg::tapWriteTag, 1'b1);
        response(hostTapPkg::eRspWrLine, 16'hFFFE, 1'b1);
        quietCycle();
    endtask

    task driveRow(input tRow r);
        psel            <= (r.op == opApbWrite) || (r.op == opApbRead);
        penable         <= 1'b0;
        pwrite          <= (r.op == opApbWrite);
        paddr           <= r.addr[hostTapPkg::apbAddrWidth-1:0];
        pwdata          <= r.data[hostTapPkg::apbDataWidth-1:0];
        afuC1TxValid    <= (r.op == opAfuBeat);
        afuC1TxType     <= r.reqType;
        afuC1TxAddr     <= r.addr;
        afuC1TxMdata    <= r.mdata;
        afuC1TxData     <= r.data;
        afuC1TxSop      <= r.sop;
        afuC1TxLen      <= r.len;
        fiuC1TxAlmFull  <= r.almFull;
        fiuC1RxValid    <= (r.op == opResponse);
        fiuC1RxType     <= r.rspType;
        fiuC1RxMdata    <= r.mdata;
        afuMmioRspValid <= (r.op == opMmioPulse);
        afuMmioRspData  <= r.data[hostTapPkg::mmioDataWidth-1:0];
    endtask

    task automatic checkWrite(input logic expValid, input hostTapPkg::tReqType expType,
                              input logic [31:0] expAddr, input logic [15:0] expMdata,
                              input logic [127:0] expData, input logic expSop,
                              input hostTapPkg::tBeatLen expLen, input logic expAlmFull);
        if (afuC1TxAlmFull !== expAlmFull)
            reportMismatch("afuC1TxAlmFull", 128'(expAlmFull), 128'(afuC1TxAlmFull));
        if (fiuC1TxValid !== expValid)
            reportMismatch("fiuC1TxValid", 128'(expValid), 128'(fiuC1TxValid));
        if (expValid)
        begin
            if (fiuC1TxType !== expType)
                reportMismatch("fiuC1TxType", 128'(expType), 128'(fiuC1TxType));
            if (fiuC1TxAddr !== expAddr)
                reportMismatch("fiuC1TxAddr", 128'(expAddr), 128'(fiuC1TxAddr));
            if (fiuC1TxMdata !== expMdata)
                reportMismatch("fiuC1TxMdata", 128'(expMdata), 128'(fiuC1TxMdata));
            if (fiuC1TxData !== expData)
                reportMismatch("fiuC1TxData", expData, fiuC1TxData);
            if (fiuC1TxSop !== expSop)
                reportMismatch("fiuC1TxSop", 128'(expSop), 128'(fiuC1TxSop));
            if (fiuC1TxLen !== expLen)
                reportMismatch("fiuC1TxLen", 128'(expLen), 128'(fiuC1TxLen));
        end
    endtask

    task automatic checkRsp(input logic expValid, input hostTapPkg::tRspType expType,
                            input logic [15:0] expMdata);
        if (afuC1RxValid !== expValid)
            reportMismatch("afuC1RxValid", 128'(expValid), 128'(afuC1RxValid));
        if (expValid && (afuC1RxType !== expType))
            reportMismatch("afuC1RxType", 128'(expType), 128'(afuC1RxType));
        if (expValid && (afuC1RxMdata !== expMdata))
            reportMismatch("afuC1RxMdata", 128'(expMdata), 128'(afuC1RxMdata));
    endtask

    task automatic checkApb(input logic [31:0] expPrdata, input logic expPslverr,
                            input logic readCycle);
        if (pready !== 1'b1)
            reportMismatch("pready", 128'(1'b1), 128'(pready));
        if (pslverr !== expPslverr)
            reportMismatch("pslverr", 128'(expPslverr), 128'(pslverr));
        if (readCycle && (prdata !== expPrdata))
            reportMismatch("prdata", 128'(expPrdata), 128'(prdata));
    endtask

    // Compares every DUT output with one row; the APB setup phase never
    // raises pslverr and its prdata is not yet valid
    task automatic compareOutputs(input tRow r, input logic setupPhase);
        checkWrite(r.expTxValid, r.expTxType, r.expTxAddr, r.expTxMdata, r.expTxData,
                   r.expTxSop, r.expTxLen, r.almFull);
        checkRsp(r.expRxValid, r.rspType, r.mdata);
        if (setupPhase)
            checkApb('0, 1'b0, 1'b0);
        else
            checkApb(r.expPrdata, r.expPslverr, r.op == opApbRead);
    endtask

    initial
    begin
        tRow current;
        reset <= 1'b1;
        driveRow(blankRow());
        buildTable();
        tableReady = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++)
        begin
            current = rows[i];
            @(posedge clk);
            driveRow(current);
            // APB rows take a setup cycle, then the access cycle
            if ((current.op == opApbWrite) || (current.op == opApbRead))
            begin
                @(negedge clk);
                compareOutputs(current, 1'b1);
                @(posedge clk);
                penable <= 1'b1;
            end
            // Outputs are combinational, so mid-cycle they are settled
            @(negedge clk);
            compareOutputs(current, 1'b0);
        end
        @(posedge clk);
        driveRow(blankRow());
        $display("sim passed");
        $finish;
    end

    // Each row gets up to 20 clock cycles
    initial
    begin
        int limitNs;
        wait (tableReady);
        limitNs = rows.size() * 20 * 8;
        #(limitNs);
        abortRun("Timeout: the stimulus table did not finish in time");
    end

endmodule

`default_nettype wire

//--- hostTapTop.sv
// Top level of the host tap: APB registers, the write-channel tap and the
// packet tracker that watches what the tap sends to the platform
`timescale 1ns/100ps
`default_nettype none

module hostTapTop
(
    input  logic                                  clk,
    input  logic                                  reset,

    // APB register port
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [hostTapPkg::apbAddrWidth-1:0]   paddr,
    input  logic [hostTapPkg::apbDataWidth-1:0]   pwdata,
    output logic [hostTapPkg::apbDataWidth-1:0]   prdata,
    output logic                                  pready,
    output logic                                  pslverr,

    // AFU side
    input  logic                                  afuC1TxValid,
    input  hostTapPkg::tReqType                   afuC1TxType,
    input  logic [hostTapPkg::lineAddrWidth-1:0]  afuC1TxAddr,
    input  logic [hostTapPkg::mdataWidth-1:0]     afuC1TxMdata,
    input  logic [hostTapPkg::lineDataWidth-1:0]  afuC1TxData,
    input  logic                                  afuC1TxSop,
    input  hostTapPkg::tBeatLen                   afuC1TxLen,
    output logic                                  afuC1TxAlmFull,
    output logic                                  afuC1RxValid,
    output hostTapPkg::tRspType                   afuC1RxType,
    output logic [hostTapPkg::mdataWidth-1:0]     afuC1RxMdata,
    input  logic                                  afuMmioRspValid,
    input  logic [hostTapPkg::mmioDataWidth-1:0]  afuMmioRspData,

    // Platform side
    output logic                                  fiuC1TxValid,
    output hostTapPkg::tReqType                   fiuC1TxType,
    output logic [hostTapPkg::lineAddrWidth-1:0]  fiuC1TxAddr,
    output logic [hostTapPkg::mdataWidth-1:0]     fiuC1TxMdata,
    output logic [hostTapPkg::lineDataWidth-1:0]  fiuC1TxData,
    output logic                                  fiuC1TxSop,
    output hostTapPkg::tBeatLen                   fiuC1TxLen,
    input  logic                                  fiuC1TxAlmFull,
    input  logic                                  fiuC1RxValid,
    input  hostTapPkg::tRspType                   fiuC1RxType,
    input  logic [hostTapPkg::mdataWidth-1:0]     fiuC1RxMdata
);

    logic [hostTapPkg::lineAddrWidth-1:0] dsmBase;
    logic                                 dsmBaseValid;
    logic                                 packetActive;

    tapCsr csr
    (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .dsmBase, .dsmBaseValid
    );

    fiuTap tap
    (
        .clk, .reset,
        .dsmBase, .dsmBaseValid, .packetActive,
        .afuC1TxValid, .afuC1TxType, .afuC1TxAddr, .afuC1TxMdata,
        .afuC1TxData, .afuC1TxSop, .afuC1TxLen, .afuC1TxAlmFull,
        .fiuC1TxValid, .fiuC1TxType, .fiuC1TxAddr, .fiuC1TxMdata,
        .fiuC1TxData, .fiuC1TxSop, .fiuC1TxLen, .fiuC1TxAlmFull,
        .fiuC1RxValid, .fiuC1RxType, .fiuC1RxMdata,
        .afuC1RxValid, .afuC1RxType, .afuC1RxMdata,
        .afuMmioRspValid, .afuMmioRspData
    );

    // Tracks the merged stream, so injected beats are counted as well
    writePacketTracker tracker
    (
        .clk, .reset,
        .c1TxValid    (fiuC1TxValid),
        .c1TxSop      (fiuC1TxSop),
        .c1TxLen      (fiuC1TxLen),
        .packetActive (packetActive)
    );

endmodule

`default_nettype wire

//--- fiuTap.sv
// Sits on the write channel between AFU and platform. AFU writes pass straight
// through; in free cycles it injects the AFU-ID and buffered MMIO read
// responses into the DSM, and it hides the responses to its own writes
`timescale 1ns/100ps
`default_nettype none

module fiuTap
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Configuration from the CSR block and packet state from the tracker
    input  logic [hostTapPkg::lineAddrWidth-1:0]  dsmBase,
    input  logic                                  dsmBaseValid,
    input  logic                                  packetActive,

    // Write requests from the AFU
    input  logic                                  afuC1TxValid,
    input  hostTapPkg::tReqType                   afuC1TxType,
    input  logic [hostTapPkg::lineAddrWidth-1:0]  afuC1TxAddr,
    input  logic [hostTapPkg::mdataWidth-1:0]     afuC1TxMdata,
    input  logic [hostTapPkg::lineDataWidth-1:0]  afuC1TxData,
    input  logic                                  afuC1TxSop,
    input  hostTapPkg::tBeatLen                   afuC1TxLen,
    output logic                                  afuC1TxAlmFull,

    // Write requests toward the platform
    output logic                                  fiuC1TxValid,
    output hostTapPkg::tReqType                   fiuC1TxType,
    output logic [hostTapPkg::lineAddrWidth-1:0]  fiuC1TxAddr,
    output logic [hostTapPkg::mdataWidth-1:0]     fiuC1TxMdata,
    output logic [hostTapPkg::lineDataWidth-1:0]  fiuC1TxData,
    output logic                                  fiuC1TxSop,
    output hostTapPkg::tBeatLen                   fiuC1TxLen,
    input  logic                                  fiuC1TxAlmFull,

    // Write responses from the platform and on to the AFU
    input  logic                                  fiuC1RxValid,
    input  hostTapPkg::tRspType                   fiuC1RxType,
    input  logic [hostTapPkg::mdataWidth-1:0]     fiuC1RxMdata,
    output logic                                  afuC1RxValid,
    output hostTapPkg::tRspType                   afuC1RxType,
    output logic [hostTapPkg::mdataWidth-1:0]     afuC1RxMdata,

    // MMIO read response pulse from the AFU
    input  logic                                  afuMmioRspValid,
    input  logic [hostTapPkg::mmioDataWidth-1:0]  afuMmioRspData
);

    localparam int padWidth = hostTapPkg::lineDataWidth - hostTapPkg::mmioDataWidth - 1;

    logic                                 didAfuIdWrite;
    logic                                 mmioBufValid;
    logic [hostTapPkg::mmioDataWidth-1:0] mmioBufData;
    logic                                 slotFree;
    logic                                 injectAfuId;
    logic                                 injectMmio;

    // A slot is free when the platform accepts writes, the AFU is quiet and
    // no multi-beat packet is half way through
    assign slotFree = dsmBaseValid && !fiuC1TxAlmFull && !afuC1TxValid && !packetActive;

    // The AFU-ID goes first; MMIO responses wait until it has been written
    assign injectAfuId = slotFree && !didAfuIdWrite;
    assign injectMmio  = slotFree && didAfuIdWrite && mmioBufValid;

    // Almost-full is shared; the tap never needs its own headroom
    assign afuC1TxAlmFull = fiuC1TxAlmFull;

    always_comb
    begin
        // AFU traffic by default
        fiuC1TxValid = afuC1TxValid;
        fiuC1TxType  = afuC1TxType;
        fiuC1TxAddr  = afuC1TxAddr;
        fiuC1TxMdata = afuC1TxMdata;
        fiuC1TxData  = afuC1TxData;
        fiuC1TxSop   = afuC1TxSop;
        fiuC1TxLen   = afuC1TxLen;

        if (injectAfuId || injectMmio)
        begin
            // Injected writes are always single-beat and tagged
            fiuC1TxValid = 1'b1;
            fiuC1TxType  = hostTapPkg::eReqWrLineI;
            fiuC1TxMdata = hostTapPkg::tapWriteTag;
            fiuC1TxSop   = 1'b1;
            fiuC1TxLen   = hostTapPkg::eLen1;

            if (injectAfuId)
            begin
                fiuC1TxAddr = dsmBase;
                fiuC1TxData = hostTapPkg::afuId;
            end
            else
            begin
                // DSM line 1 holds the response in the low bits and bit 64 marks it written
                fiuC1TxAddr = dsmBase + hostTapPkg::lineAddrWidth'(1);
                fiuC1TxData = {{padWidth{1'b0}}, 1'b1, mmioBufData};
            end
        end
    end

    // Responses pass through except write-line completions of our own writes
    assign afuC1RxType  = fiuC1RxType;
    assign afuC1RxMdata = fiuC1RxMdata;
    assign afuC1RxValid = fiuC1RxValid &&
                          !((fiuC1RxType == hostTapPkg::eRspWrLine) &&
                            (fiuC1RxMdata == hostTapPkg::tapWriteTag));

    // Dropping the valid flag arms a fresh AFU-ID write for the next base
    always_ff @(posedge clk)
    begin
        if (reset || !dsmBaseValid)
            didAfuIdWrite <= 1'b0;
        else if (injectAfuId)
            didAfuIdWrite <= 1'b1;
    end

    // One-deep MMIO response buffer; a pulse that arrives while full is lost
    always_ff @(posedge clk)
    begin
        if (reset)
            mmioBufValid <= 1'b0;
        else if (injectMmio)
            mmioBufValid <= 1'b0;
        else if (afuMmioRspValid)
            mmioBufValid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!mmioBufValid && afuMmioRspValid)
            mmioBufData <= afuMmioRspData;
    end

endmodule

`default_nettype wire

//--- tapCsr.sv
// APB register block for the tap: DSM base line address and its valid flag
// Offset 0 holds the base address, offset 4 bit 0 holds the valid flag
`timescale 1ns/100ps
`default_nettype none

module tapCsr
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [hostTapPkg::apbAddrWidth-1:0] paddr,
    input  logic [hostTapPkg::apbDataWidth-1:0] pwdata,
    output logic [hostTapPkg::apbDataWidth-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic [hostTapPkg::lineAddrWidth-1:0] dsmBase,
    output logic                                dsmBaseValid
);

    hostTapPkg::tCsrReg regSel;
    logic               regHit;
    logic               accessPhase;

    // Register index sits in bits 3:2; anything above must be zero for a hit
    assign regSel = hostTapPkg::tCsrReg'(paddr[3:2]);
    assign regHit = (paddr[hostTapPkg::apbAddrWidth-1:4] == '0) &&
                    ((regSel == hostTapPkg::eCsrDsmBase) ||
                     (regSel == hostTapPkg::eCsrCtrl));

    assign accessPhase = psel && penable;

    // No wait states
    assign pready = 1'b1;

    // Error only in the access phase of an unmapped address
    assign pslverr = accessPhase && !regHit;

    // Writes land on the access-phase clock edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dsmBase      <= '0;
            dsmBaseValid <= 1'b0;
        end
        else if (accessPhase && pwrite && regHit)
        begin
            if (regSel == hostTapPkg::eCsrDsmBase)
                dsmBase <= pwdata[hostTapPkg::lineAddrWidth-1:0];
            else
                dsmBaseValid <= pwdata[0];
        end
    end

    // Read mux; unmapped offsets read as zero
    always_comb
    begin
        prdata = '0;
        if (regHit)
        begin
            if (regSel == hostTapPkg::eCsrDsmBase)
                prdata[hostTapPkg::lineAddrWidth-1:0] = dsmBase;
            else
                prdata[0] = dsmBaseValid;
        end
    end

endmodule

`default_nettype wire

//--- writePacketTracker.sv
// Watches the platform-side write channel and reports when a multi-beat
// packet is still open, so that nothing gets inserted between its beats
`timescale 1ns/100ps
`default_nettype none

module writePacketTracker
(
    input  logic                clk,
    input  logic                reset,
    input  logic                c1TxValid,
    input  logic                c1TxSop,
    input  hostTapPkg::tBeatLen c1TxLen,
    output logic                packetActive
);

    // Beats still owed by the current packet, zero when no packet is open
    logic [1:0] beatsLeft;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beatsLeft <= 2'd0;
        end
        else if (c1TxValid && c1TxSop)
        begin
            // The first beat is on the wire now; the rest are still to come
            case (c1TxLen)
                hostTapPkg::eLen2: beatsLeft <= 2'd1;
                hostTapPkg::eLen4: beatsLeft <= 2'd3;
                default:           beatsLeft <= 2'd0;
            endcase
        end
        else if (c1TxValid && (beatsLeft != 2'd0))
        begin
            // A continuation beat
            beatsLeft <= beatsLeft - 2'd1;
        end
    end

    // Low on the Sop beat itself and for single-beat packets
    assign packetActive = (beatsLeft != 2'd0);

endmodule

`default_nettype wire

//--- hostTapPkg.sv
// Shared widths, tags and encodings for the host-interface tap
// Compile this package first; every other file refers to it by scoped name
`default_nettype none

package hostTapPkg;

    // Cache-line address and one write beat of data
    localparam int lineAddrWidth = 32;
    localparam int lineDataWidth = 128;

    // Request metadata carried on writes and echoed back on responses
    localparam int mdataWidth = 16;

    // Payload of one MMIO read response from the AFU
    localparam int mmioDataWidth = 64;

    // APB register port, byte addressed
    localparam int apbAddrWidth = 8;
    localparam int apbDataWidth = 32;

    // Every write the tap generates carries this tag so its response can be dropped
    localparam logic [mdataWidth-1:0] tapWriteTag = 16'hFFFF;

    // Identifier placed at the DSM base once the base becomes valid
    localparam logic [lineDataWidth-1:0] afuId = 128'h5037b187_e5614ca2_ad5b2f6b_f7c4d5a2;

    // Write request opcodes
    typedef enum logic [1:0] {
        eReqWrLineI = 2'd0,
        eReqWrLineM = 2'd1,
        eReqWrFence = 2'd2
    } tReqType;

    // Write channel response opcodes
    typedef enum logic {
        eRspWrLine  = 1'b0,
        eRspWrFence = 1'b1
    } tRspType;

    // Packet length, encoded as the number of beats minus one
    typedef enum logic [1:0] {
        eLen1 = 2'd0,
        eLen2 = 2'd1,
        eLen4 = 2'd3
    } tBeatLen;

    // CSR index, taken from paddr[3:2]
    typedef enum logic [1:0] {
        eCsrDsmBase = 2'd0,
        eCsrCtrl    = 2'd1
    } tCsrReg;

endpackage

`default_nettype wire
